// File: Bender.yml
package:
  name: lsu

export_include_dirs:
  - include

sources:
  - files:
      - source/lsqPkg.sv
      - source/ringPointer.sv
      - source/lsqControl.sv
      - source/entryRam.sv
      - source/loadForwardPipe.sv
      - source/loadViolationCheck.sv
      - source/lsuTop.sv
  - target: simulation
    files:
      - verification/lsuMemModel.sv
      - verification/lsuTb.sv

// File: include/lsq_macros.svh
`ifndef LSQ_MACROS_SVH
`define LSQ_MACROS_SVH

`define LSQ_DEPTH  8   // entries per queue, power of two
`define LSQ_IDX_W  3   // log2 of queue depth

`define ADDR_W     32  // full word address
`define DATA_W     32  // full word data

`define MEM_RD_LAT 1   // ldEn to ldData, in cycles

`endif

// File: sim.f
+incdir+include
source/lsqPkg.sv
source/ringPointer.sv
source/lsqControl.sv
source/entryRam.sv
source/loadForwardPipe.sv
source/loadViolationCheck.sv
source/lsuTop.sv
verification/lsuMemModel.sv
verification/lsuTb.sv

// File: source/entryRam.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsq_macros.svh"

module entryRam #(
  parameter type entryT = logic  // LQ or SQ entry layout
) (
  input  logic                   clk,
  input  logic                   allocEn_i,   // dispatch writes a fresh entry
  input  logic [`LSQ_IDX_W-1:0]  allocIdx_i,
  input  entryT                  allocVal_i,
  input  logic                   updEn_i,     // AGEN fills in an entry
  input  logic [`LSQ_IDX_W-1:0]  updIdx_i,
  input  entryT                  updVal_i,
  output entryT [`LSQ_DEPTH-1:0] entries_o    // all entries, for the CAM searches
);

  // update port has priority over allocation on the same slot
  always_ff @(posedge clk) begin
    for (int i = 0; i < `LSQ_DEPTH; i++) begin
      if (updEn_i && (updIdx_i == `LSQ_IDX_W'(i))) begin
        entries_o[i] <= updVal_i;
      end else if (allocEn_i && (allocIdx_i == `LSQ_IDX_W'(i))) begin
        entries_o[i] <= allocVal_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/loadForwardPipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsq_macros.svh"

module loadForwardPipe (
  input  logic                             clk,
  input  logic                             reset_i,
  input  lsqPkg::memPktT                   agenPkt_i,
  input  logic                             flush_i,
  input  lsqPkg::stEntryT [`LSQ_DEPTH-1:0] sqEntries_i,
  input  lsqPkg::lsqIdT                    sqHead_i,
  input  lsqPkg::lsqIdT                    ldStMark_i,   // stMark of the executing load
  output logic                             ldEn_o,
  output logic [`ADDR_W-1:0]               ldAddr_o,
  input  logic [`DATA_W-1:0]               ldData_i,     // one cycle after ldEn_o
  output lsqPkg::ldEntryT                  ldUpd_o,
  output lsqPkg::wbPktT                    wbPkt_o
);
  import lsqPkg::*;

  logic [`LSQ_IDX_W:0]   olderCnt;   // stores older than the load
  logic                  fwdHit;
  lsqIdT                 fwdSrc;
  logic [`DATA_W-1:0]    fwdData;

  logic                  s1Valid;    // stage two, waiting on memory
  logic [`LSQ_IDX_W-1:0] s1LsqId;
  logic                  s1Fwd;
  logic [`DATA_W-1:0]    s1FwdData;

  // memory read starts in the AGEN cycle
  assign ldEn_o   = agenPkt_i.valid & agenPkt_i.isLoad;
  assign ldAddr_o = agenPkt_i.addr;

  // older stores sit in [sqHead, stMark)
  assign olderCnt = {ldStMark_i.wrap, ldStMark_i.idx} - {sqHead_i.wrap, sqHead_i.idx};

  // walk back from stMark, nearest hit is the youngest older store
  always_comb begin : fwdSearch
    lsqIdT cand;
    fwdHit  = 1'b0;
    fwdSrc  = '0;
    fwdData = '0;
    for (int k = `LSQ_DEPTH; k >= 1; k--) begin
      cand = lsqIdT'({ldStMark_i.wrap, ldStMark_i.idx} - (`LSQ_IDX_W + 1)'(k));
      if ((k <= olderCnt) && sqEntries_i[cand.idx].addrValid &&
          (sqEntries_i[cand.idx].addr == agenPkt_i.addr)) begin  // unknown addr skipped
        fwdHit  = 1'b1;
        fwdSrc  = cand;
        fwdData = sqEntries_i[cand.idx].data;
      end
    end
  end

  // LQ entry after execution, stMark kept
  always_comb begin
    ldUpd_o.addrValid = 1'b1;
    ldUpd_o.executed  = 1'b1;
    ldUpd_o.addr      = agenPkt_i.addr;
    ldUpd_o.stMark    = ldStMark_i;
    ldUpd_o.fwdValid  = fwdHit;
    ldUpd_o.fwdFrom   = fwdSrc;   // checked later by store violation search
  end

  // stage one register
  always_ff @(posedge clk) begin
    if (reset_i) begin
      s1Valid <= 1'b0;
    end else begin
      s1Valid <= ldEn_o;
    end
    s1LsqId   <= agenPkt_i.lsqId;
    s1Fwd     <= fwdHit;
    s1FwdData <= fwdData;
  end

  // stage two, store data beats memory data
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wbPkt_o.valid <= 1'b0;
    end else begin
      wbPkt_o.valid <= s1Valid & ~flush_i;  // in-flight load dies on recovery
    end
    wbPkt_o.isLoad <= 1'b1;
    wbPkt_o.lsqId  <= s1LsqId;
    wbPkt_o.data   <= s1Fwd ? s1FwdData : ldData_i;
  end

endmodule

`default_nettype wire

// File: source/loadViolationCheck.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsq_macros.svh"

module loadViolationCheck (
  input  logic                             clk,
  input  logic                             reset_i,
  input  lsqPkg::memPktT                   agenPkt_i,
  input  lsqPkg::ldEntryT [`LSQ_DEPTH-1:0] lqEntries_i,
  input  lsqPkg::lsqIdT                    lqHead_i,
  input  lsqPkg::lsqIdT                    lqTail_i,
  input  lsqPkg::lsqIdT                    sqHead_i,     // age origin for SQ positions
  output lsqPkg::stEntryT                  stUpd_o,
  output lsqPkg::wbPktT                    stWb_o,
  output lsqPkg::vioPktT                   vioPkt_o
);
  import lsqPkg::*;

  logic                  stExec;
  logic [`LSQ_IDX_W:0]   stPos;     // store age from SQ head
  logic [`LSQ_IDX_W:0]   lqCnt;     // live loads
  logic [`LSQ_DEPTH-1:0] ldHit;
  logic                  vioFound;
  logic [`LSQ_IDX_W-1:0] vioIdx;

  assign stExec = agenPkt_i.valid & ~agenPkt_i.isLoad;
  assign stPos  = {1'b0, agenPkt_i.lsqId - sqHead_i.idx};  // store is always live
  assign lqCnt  = {lqTail_i.wrap, lqTail_i.idx} - {lqHead_i.wrap, lqHead_i.idx};

  // per entry: executed, same address, younger, not fed by this store or later
  always_comb begin : hitScan
    logic [`LSQ_IDX_W:0] ldPos;
    logic [`LSQ_IDX_W:0] fwdPos;
    logic                younger;
    logic                fedLater;
    for (int i = 0; i < `LSQ_DEPTH; i++) begin
      ldPos  = {lqEntries_i[i].stMark.wrap, lqEntries_i[i].stMark.idx} -
               {sqHead_i.wrap, sqHead_i.idx};
      fwdPos = {lqEntries_i[i].fwdFrom.wrap, lqEntries_i[i].fwdFrom.idx} -
               {sqHead_i.wrap, sqHead_i.idx};
      younger  = ldPos > stPos;   // store lies before the load's stMark
      fedLater = lqEntries_i[i].fwdValid & ~fwdPos[`LSQ_IDX_W] &  // msb set, source retired
                 (fwdPos >= stPos);
      ldHit[i] = lqEntries_i[i].executed & lqEntries_i[i].addrValid &
                 (lqEntries_i[i].addr == agenPkt_i.addr) & younger & ~fedLater;
    end
  end

  // oldest live hit, scanned from LQ head
  always_comb begin : oldestPick
    logic [`LSQ_IDX_W-1:0] idx;
    vioFound = 1'b0;
    vioIdx   = '0;
    for (int k = `LSQ_DEPTH - 1; k >= 0; k--) begin
      idx = lqHead_i.idx + `LSQ_IDX_W'(k);
      if ((k < lqCnt) && ldHit[idx]) begin
        vioFound = 1'b1;
        vioIdx   = idx;
      end
    end
  end

  always_comb begin
    stUpd_o.addrValid = 1'b1;
    stUpd_o.addr      = agenPkt_i.addr;
    stUpd_o.data      = agenPkt_i.data;
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      stWb_o.valid   <= 1'b0;
      vioPkt_o.valid <= 1'b0;
    end else begin
      stWb_o.valid   <= stExec;
      vioPkt_o.valid <= stExec & vioFound;
    end
    stWb_o.isLoad  <= 1'b0;
    stWb_o.lsqId   <= agenPkt_i.lsqId;
    stWb_o.data    <= agenPkt_i.data;
    vioPkt_o.ldqId <= vioIdx;
  end

endmodule

`default_nettype wire

// File: source/lsqControl.sv
`timescale 1ns/1ps
`default_nettype none

module lsqControl (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            recover_i,
  input  lsqPkg::dispPktT dispatch_i,
  input  lsqPkg::memPktT  memPkt_i,
  input  logic            commitLoad_i,
  input  logic            commitStore_i,
  output logic            ldAlloc_o,    // allocate at LQ tail
  output logic            stAlloc_o,    // allocate at SQ tail
  output lsqPkg::memPktT  agenPkt_o,    // AGEN packet after gating
  output logic            commitLd_o,   // retire LQ head
  output logic            commitSt_o,   // retire SQ head
  output logic            flush_o,      // recover cycle plus FLUSH cycle
  output logic            ldqCredit_o,
  output logic            stqCredit_o
);

  typedef enum logic {
    RUN,
    FLUSH
  } ctlStateT;

  ctlStateT state;
  ctlStateT stateNext;

  always_comb begin
    stateNext = state;
    case (state)
      RUN: begin
        if (recover_i) begin
          stateNext = FLUSH;
        end
      end
      FLUSH: begin
        stateNext = recover_i ? FLUSH : RUN;  // back to back recovery stays
      end
      default: begin
        stateNext = RUN;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state <= RUN;
    end else begin
      state <= stateNext;
    end
  end

  assign flush_o = recover_i | (state == FLUSH);

  // everything from the core is dropped while flushing
  assign ldAlloc_o  = dispatch_i.valid & dispatch_i.isLoad & ~flush_o;
  assign stAlloc_o  = dispatch_i.valid & ~dispatch_i.isLoad & ~flush_o;
  assign commitLd_o = commitLoad_i & ~flush_o;
  assign commitSt_o = commitStore_i & ~flush_o;

  always_comb begin
    agenPkt_o       = memPkt_i;
    agenPkt_o.valid = memPkt_i.valid & ~flush_o;  // squashed op never executes
  end

  // one credit per freed entry, one cycle after commit
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ldqCredit_o <= 1'b0;
      stqCredit_o <= 1'b0;
    end else begin
      ldqCredit_o <= commitLd_o;
      stqCredit_o <= commitSt_o;
    end
  end

endmodule

`default_nettype wire

// File: source/lsqPkg.sv
`default_nettype none

`include "lsq_macros.svh"

package lsqPkg;

  // queue position, wrap bit tells full from empty
  typedef struct packed {
    logic                  wrap;
    logic [`LSQ_IDX_W-1:0] idx;
  } lsqIdT;

  typedef struct packed {
    logic valid;
    logic isLoad;  // 0 means store
  } dispPktT;

  // packet from AGEN
  typedef struct packed {
    logic                  valid;
    logic                  isLoad;
    logic [`LSQ_IDX_W-1:0] lsqId;   // LQ or SQ entry
    logic [`ADDR_W-1:0]    addr;
    logic [`DATA_W-1:0]    data;    // stores only
  } memPktT;

  typedef struct packed {
    logic               addrValid;
    logic               executed;  // load already read its data
    logic [`ADDR_W-1:0] addr;
    lsqIdT              stMark;    // SQ tail at dispatch
    logic               fwdValid;
    lsqIdT              fwdFrom;   // store that supplied the data
  } ldEntryT;

  typedef struct packed {
    logic               addrValid;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] data;
  } stEntryT;

  typedef struct packed {
    logic                  valid;
    logic                  isLoad;
    logic [`LSQ_IDX_W-1:0] lsqId;
    logic [`DATA_W-1:0]    data;
  } wbPktT;

  typedef struct packed {
    logic                  valid;
    logic [`LSQ_IDX_W-1:0] ldqId;  // oldest offending load
  } vioPktT;

  typedef struct packed {
    logic               en;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] data;
  } memWrT;

endpackage

`default_nettype wire

// File: source/lsuTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsq_macros.svh"

module lsuTop (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  recoverFlag_i,
  input  lsqPkg::dispPktT       dispatch_i,
  output logic [`LSQ_IDX_W-1:0] lsqId_o,        // tail of the chosen queue
  input  lsqPkg::memPktT        memPkt_i,
  input  logic                  commitLoad_i,
  input  logic                  commitStore_i,
  output logic                  ldqCredit_o,
  output logic                  stqCredit_o,
  output logic                  ldEn_o,
  output logic [`ADDR_W-1:0]    ldAddr_o,
  input  logic [`DATA_W-1:0]    ldData_i,
  output lsqPkg::memWrT         memWr_o,
  output lsqPkg::wbPktT         wbPkt_o,
  output lsqPkg::vioPktT        vioPkt_o
);
  import lsqPkg::*;

  logic                   ldAlloc;
  logic                   stAlloc;
  memPktT                 agenPkt;
  logic                   commitLd;
  logic                   commitSt;
  logic                   flush;
  lsqIdT                  lqHead;
  lsqIdT                  lqTail;
  lsqIdT                  sqHead;
  lsqIdT                  sqTail;
  ldEntryT [`LSQ_DEPTH-1:0] lqEntries;
  stEntryT [`LSQ_DEPTH-1:0] sqEntries;
  ldEntryT                ldAllocVal;
  stEntryT                stAllocVal;
  ldEntryT                ldUpd;
  stEntryT                stUpd;
  wbPktT                  ldWb;
  wbPktT                  stWb;

  lsqControl control (
    .clk, .reset_i, .recover_i(recoverFlag_i), .dispatch_i, .memPkt_i,
    .commitLoad_i, .commitStore_i, .ldAlloc_o(ldAlloc), .stAlloc_o(stAlloc),
    .agenPkt_o(agenPkt), .commitLd_o(commitLd), .commitSt_o(commitSt), .flush_o(flush),
    .ldqCredit_o, .stqCredit_o
  );

  // heads move on commit, tails on dispatch and snap to head on flush
  ringPointer lqHeadPtr (.clk, .reset_i, .advance_i(commitLd), .restore_i(1'b0),
                         .restoreVal_i(lqHead), .ptr_o(lqHead));
  ringPointer lqTailPtr (.clk, .reset_i, .advance_i(ldAlloc), .restore_i(flush),
                         .restoreVal_i(lqHead), .ptr_o(lqTail));
  ringPointer sqHeadPtr (.clk, .reset_i, .advance_i(commitSt), .restore_i(1'b0),
                         .restoreVal_i(sqHead), .ptr_o(sqHead));
  ringPointer sqTailPtr (.clk, .reset_i, .advance_i(stAlloc), .restore_i(flush),
                         .restoreVal_i(sqHead), .ptr_o(sqTail));

  assign lsqId_o = dispatch_i.isLoad ? lqTail.idx : sqTail.idx;

  always_comb begin
    ldAllocVal        = '0;
    ldAllocVal.stMark = sqTail;  // age mark against the stores
    stAllocVal        = '0;
  end

  entryRam #(.entryT(ldEntryT)) lqRam (
    .clk, .allocEn_i(ldAlloc), .allocIdx_i(lqTail.idx), .allocVal_i(ldAllocVal),
    .updEn_i(agenPkt.valid & agenPkt.isLoad), .updIdx_i(agenPkt.lsqId),
    .updVal_i(ldUpd), .entries_o(lqEntries)
  );

  entryRam #(.entryT(stEntryT)) sqRam (
    .clk, .allocEn_i(stAlloc), .allocIdx_i(sqTail.idx), .allocVal_i(stAllocVal),
    .updEn_i(agenPkt.valid & ~agenPkt.isLoad), .updIdx_i(agenPkt.lsqId),
    .updVal_i(stUpd), .entries_o(sqEntries)
  );

  loadForwardPipe ldPipe (
    .clk, .reset_i, .agenPkt_i(agenPkt), .flush_i(flush), .sqEntries_i(sqEntries),
    .sqHead_i(sqHead), .ldStMark_i(lqEntries[agenPkt.lsqId].stMark),
    .ldEn_o, .ldAddr_o, .ldData_i, .ldUpd_o(ldUpd), .wbPkt_o(ldWb)
  );

  loadViolationCheck stCheck (
    .clk, .reset_i, .agenPkt_i(agenPkt), .lqEntries_i(lqEntries),
    .lqHead_i(lqHead), .lqTail_i(lqTail), .sqHead_i(sqHead),
    .stUpd_o(stUpd), .stWb_o(stWb), .vioPkt_o
  );

  // store write-back wins, AGEN keeps loads out of the slot
  assign wbPkt_o = stWb.valid ? stWb : ldWb;

  // retired store leaves from the SQ head one cycle after commit
  always_ff @(posedge clk) begin
    if (reset_i) begin
      memWr_o.en <= 1'b0;
    end else begin
      memWr_o.en <= commitSt;
    end
    memWr_o.addr <= sqEntries[sqHead.idx].addr;
    memWr_o.data <= sqEntries[sqHead.idx].data;
  end

endmodule

`default_nettype wire

// File: source/ringPointer.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsq_macros.svh"

module ringPointer (
  input  logic          clk,
  input  logic          reset_i,
  input  logic          advance_i,     // step by one entry
  input  logic          restore_i,     // load restoreVal_i, beats advance
  input  lsqPkg::lsqIdT restoreVal_i,
  output lsqPkg::lsqIdT ptr_o
);
  import lsqPkg::*;

  lsqIdT nextPtr;

  always_comb begin
    nextPtr = ptr_o;                                       // hold by default
    if (restore_i) begin
      nextPtr = restoreVal_i;
    end else if (advance_i) begin
      if (ptr_o.idx == `LSQ_IDX_W'(`LSQ_DEPTH - 1)) begin  // last slot
        nextPtr.idx  = '0;
        nextPtr.wrap = ~ptr_o.wrap;                        // lap marker flips
      end else begin
        nextPtr.idx = ptr_o.idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ptr_o <= '0;  // empty queue, head equals tail
    end else begin
      ptr_o <= nextPtr;
    end
  end

endmodule

`default_nettype wire

// File: verification/lsuMemModel.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsq_macros.svh"

module lsuMemModel (
  input  logic               clk,
  input  logic               ldEn_i,
  input  logic [`ADDR_W-1:0] ldAddr_i,
  output logic [`DATA_W-1:0] ldData_o,   // valid one cycle after ldEn_i
  input  lsqPkg::memWrT      memWr_i,
  output int                 storeCnt_o  // stores applied so far
);
  import lsqPkg::*;

  logic [`DATA_W-1:0] mem [logic [`ADDR_W-1:0]];  // sparse, only written words

  // untouched words read as their address xor a fixed pattern
  function automatic logic [`DATA_W-1:0] readWord(input logic [`ADDR_W-1:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return a ^ 32'h5a5a0000;
  endfunction

  initial begin
    storeCnt_o = 0;
    ldData_o   = '0;
  end

  always @(posedge clk) begin
    if (ldEn_i) begin
      ldData_o <= readWord(ldAddr_i);  // read before same-cycle write
    end
    if (memWr_i.en) begin
      mem[memWr_i.addr] = memWr_i.data;
      storeCnt_o       <= storeCnt_o + 1;  // store log count
    end
  end

endmodule

`default_nettype wire

// File: verification/lsuTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsq_macros.svh"

module lsuTb;
  import lsqPkg::*;

  localparam int D          = `LSQ_DEPTH;
  localparam int MAX_CYCLES = 6 * 50 + 100;  // six phases plus margin

  logic                  clk;
  logic                  reset_i;
  logic                  recoverFlag_i;
  dispPktT               dispatch_i;
  logic [`LSQ_IDX_W-1:0] lsqId_o;
  memPktT                memPkt_i;
  logic                  commitLoad_i;
  logic                  commitStore_i;
  logic                  ldqCredit_o;
  logic                  stqCredit_o;
  logic                  ldEn_o;
  logic [`ADDR_W-1:0]    ldAddr_o;
  logic [`DATA_W-1:0]    ldData_i;
  memWrT                 memWr_o;
  wbPktT                 wbPkt_o;
  vioPktT                vioPkt_o;
  int                    storeCnt;

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  logic [31:0] rngState;

  // reference model with queue positions as running counters
  int lqHead = 0;
  int lqTail = 0;
  int stHead = 0;
  int stTail = 0;                 // also the next store sequence number
  int ldCredits = D;
  int stCredits = D;
  int ldPulseCnt = 0;
  int stPulseCnt = 0;
  int          ldMark [D];        // store count at load dispatch
  logic        ldExec [D];
  logic [31:0] ldAddr [D];
  logic        ldFwd [D];
  int          ldFwdSeq [D];
  logic        stKnown [D];
  logic [31:0] stAddr [D];
  logic [31:0] stData [D];
  logic [31:0] refMem [logic [31:0]];

  lsuTop uut (.*);

  lsuMemModel memory (
    .clk, .ldEn_i(ldEn_o), .ldAddr_i(ldAddr_o), .ldData_o(ldData_i),
    .memWr_i(memWr_o), .storeCnt_o(storeCnt)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (!reset_i && ldqCredit_o) begin
      ldCredits++;
      ldPulseCnt++;
    end
    if (!reset_i && stqCredit_o) begin
      stCredits++;
      stPulseCnt++;
    end
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: test sequence did not finish within %0d cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic flagError(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  // protocol timing sampled at the clock edge
  assert property (@(posedge clk) disable iff (reset_i) commitLoad_i |=> ldqCredit_o)
    else flagError("no load credit after commit");
  assert property (@(posedge clk) disable iff (reset_i) ldqCredit_o |-> $past(commitLoad_i))
    else flagError("stray load credit");
  assert property (@(posedge clk) disable iff (reset_i) commitStore_i |=> stqCredit_o)
    else flagError("no store credit after commit");
  assert property (@(posedge clk) disable iff (reset_i) stqCredit_o |-> $past(commitStore_i))
    else flagError("stray store credit");
  assert property (@(posedge clk) disable iff (reset_i) commitStore_i |=> memWr_o.en)
    else flagError("committed store not on memWr_o");
  assert property (@(posedge clk) disable iff (reset_i) memWr_o.en |-> $past(commitStore_i))
    else flagError("memWr_o without commit");
  assert property (@(posedge clk) disable iff (reset_i)
                   recoverFlag_i |=> !ldqCredit_o && !stqCredit_o)
    else flagError("credit pulse after recovery");
  assert property (@(posedge clk) $fell(reset_i) |->
                   !wbPkt_o.valid && !vioPkt_o.valid && !memWr_o.en && !ldEn_o)
    else flagError("outputs active after reset");

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] nextRand();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  function automatic logic [31:0] pickAddr();
    return 32'h0000_1000 + ((nextRand() & 32'h3) << 2);  // pool of 4 words
  endfunction

  function automatic logic [31:0] refRead(input logic [31:0] a);
    if (refMem.exists(a)) begin
      return refMem[a];
    end
    return a ^ 32'h5a5a0000;
  endfunction

  task automatic checkVal(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic idleInputs();
    dispatch_i    <= '0;
    memPkt_i      <= '0;
    commitLoad_i  <= 1'b0;
    commitStore_i <= 1'b0;
    recoverFlag_i <= 1'b0;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      idleInputs();
    end
  endtask

  task automatic dispatchOp(input logic isLoad);
    if ((isLoad && ldCredits == 0) || (!isLoad && stCredits == 0)) begin
      errors++;
      $display("dispatcher ran out of credits at %0t", $time);
    end
    @(posedge clk);
    idleInputs();
    dispatch_i <= '{valid: 1'b1, isLoad: isLoad};
    @(negedge clk);
    if (isLoad) begin
      checkVal("load lsqId_o", 32'(lsqId_o), lqTail % D);
      ldMark[lqTail % D] = stTail;
      ldExec[lqTail % D] = 1'b0;
      ldFwd[lqTail % D]  = 1'b0;
      lqTail++;
      ldCredits--;
    end else begin
      checkVal("store lsqId_o", 32'(lsqId_o), stTail % D);
      stKnown[stTail % D] = 1'b0;
      stTail++;
      stCredits--;
    end
  endtask

  // load at t with write-back expected at t+2
  task automatic loadAgen(input int ld, input logic [31:0] addr);
    int          s;
    int          slot;
    logic        fwd;
    int          fwdSeq;
    logic [31:0] expData;
    slot    = ld % D;
    fwd     = 1'b0;
    fwdSeq  = 0;
    expData = refRead(addr);
    for (s = ldMark[slot] - 1; s >= stHead; s--) begin  // youngest older store first
      if (!fwd && stKnown[s % D] && stAddr[s % D] == addr) begin
        fwd     = 1'b1;
        fwdSeq  = s;
        expData = stData[s % D];
      end
    end
    @(posedge clk);
    idleInputs();
    memPkt_i <= '{valid: 1'b1, isLoad: 1'b1, lsqId: 3'(slot), addr: addr, data: '0};
    @(negedge clk);
    checkVal("ldEn_o", 32'(ldEn_o), 1);
    checkVal("ldAddr_o", ldAddr_o, addr);
    idleCycles(2);
    @(negedge clk);
    checkVal("load wb valid", 32'(wbPkt_o.valid), 1);
    checkVal("load wb isLoad", 32'(wbPkt_o.isLoad), 1);
    checkVal("load wb lsqId", 32'(wbPkt_o.lsqId), slot);
    checkVal("load wb data", wbPkt_o.data, expData);
    ldExec[slot]   = 1'b1;
    ldAddr[slot]   = addr;
    ldFwd[slot]    = fwd;
    ldFwdSeq[slot] = fwdSeq;
  endtask

  // store at t with write-back and violation at t+1
  task automatic storeAgen(input int seq, input logic [31:0] addr, input logic [31:0] data);
    int   k;
    int   slot;
    logic vio;
    int   vioId;
    vio   = 1'b0;
    vioId = 0;
    for (k = lqHead; k < lqTail; k++) begin  // oldest load first
      slot = k % D;
      if (!vio && ldExec[slot] && ldAddr[slot] == addr && ldMark[slot] > seq &&
          !(ldFwd[slot] && ldFwdSeq[slot] >= seq)) begin
        vio   = 1'b1;
        vioId = slot;
      end
    end
    @(posedge clk);
    idleInputs();
    memPkt_i <= '{valid: 1'b1, isLoad: 1'b0, lsqId: 3'(seq % D), addr: addr, data: data};
    idleCycles(1);
    @(negedge clk);
    checkVal("store wb valid", 32'(wbPkt_o.valid), 1);
    checkVal("store wb isLoad", 32'(wbPkt_o.isLoad), 0);
    checkVal("store wb lsqId", 32'(wbPkt_o.lsqId), seq % D);
    checkVal("store wb data", wbPkt_o.data, data);
    checkVal("vioPkt_o valid", 32'(vioPkt_o.valid), 32'(vio));
    if (vio) begin
      checkVal("vioPkt_o ldqId", 32'(vioPkt_o.ldqId), vioId);
    end
    stKnown[seq % D] = 1'b1;
    stAddr[seq % D]  = addr;
    stData[seq % D]  = data;
  endtask

  task automatic commitLoadOp();
    @(posedge clk);
    idleInputs();
    commitLoad_i <= 1'b1;
    lqHead++;
  endtask

  task automatic commitStoreOp();
    int slot;
    slot = stHead % D;
    @(posedge clk);
    idleInputs();
    commitStore_i <= 1'b1;
    idleCycles(1);
    @(negedge clk);
    if (stKnown[slot]) begin  // unexecuted stores carry no defined address
      checkVal("memWr_o addr", memWr_o.addr, stAddr[slot]);
      checkVal("memWr_o data", memWr_o.data, stData[slot]);
      refMem[stAddr[slot]] = stData[slot];
    end
    stHead++;
  endtask

  // loads at t-1 and t with recovery at t and dispatch at t+2
  task automatic recoverOp(input int ld, input logic [31:0] addr);
    @(posedge clk);
    idleInputs();
    memPkt_i <= '{valid: 1'b1, isLoad: 1'b1, lsqId: 3'(ld % D), addr: addr, data: '0};
    @(posedge clk);
    idleInputs();
    recoverFlag_i <= 1'b1;
    memPkt_i      <= '{valid: 1'b1, isLoad: 1'b1, lsqId: 3'(ld % D), addr: addr, data: '0};
    idleCycles(1);
    @(negedge clk);
    checkVal("wb valid at t+1 after recovery", 32'(wbPkt_o.valid), 0);
    lqTail    = lqHead;  // squash everything uncommitted
    stTail    = stHead;
    ldCredits = D;
    stCredits = D;
    dispatchOp(1'b1);
    checkVal("wb valid at t+2 after recovery", 32'(wbPkt_o.valid), 0);
  endtask

  initial begin : mainFlow
    int          sBase;
    int          lBase;
    int          ldPulses0;
    int          stPulses0;
    logic [31:0] addrA;
    rngState      = 32'h979c0ede;
    clk           = 1'b0;
    reset_i       = 1'b1;
    recoverFlag_i = 1'b0;
    dispatch_i    = '0;
    memPkt_i      = '0;
    commitLoad_i  = 1'b0;
    commitStore_i = 1'b0;
    repeat (3) @(posedge clk);
    reset_i <= 1'b0;

    // fill both queues and drain
    ldPulses0 = ldPulseCnt;
    stPulses0 = stPulseCnt;
    repeat (D) dispatchOp(1'b1);
    repeat (D) dispatchOp(1'b0);
    repeat (D) commitLoadOp();
    repeat (D) commitStoreOp();
    idleCycles(2);
    checkVal("load credits returned", ldPulseCnt - ldPulses0, D);
    checkVal("store credits returned", stPulseCnt - stPulses0, D);

    // plain load from memory
    lBase = lqTail;
    dispatchOp(1'b1);
    loadAgen(lBase, pickAddr());
    commitLoadOp();

    // forwarding with order S S L S S L
    addrA = pickAddr();
    sBase = stTail;
    lBase = lqTail;
    dispatchOp(1'b0);
    dispatchOp(1'b0);
    dispatchOp(1'b1);
    dispatchOp(1'b0);
    dispatchOp(1'b0);
    dispatchOp(1'b1);
    storeAgen(sBase, addrA, nextRand());
    storeAgen(sBase + 1, addrA, nextRand());
    storeAgen(sBase + 2, addrA, nextRand());  // younger than first load
    loadAgen(lBase, addrA);
    loadAgen(lBase + 1, addrA);               // fourth store still unknown
    repeat (2) commitLoadOp();
    repeat (4) commitStoreOp();

    // violations with S L L then S S L
    addrA = pickAddr();
    sBase = stTail;
    lBase = lqTail;
    dispatchOp(1'b0);
    dispatchOp(1'b1);
    dispatchOp(1'b1);
    loadAgen(lBase, addrA);
    loadAgen(lBase + 1, addrA);
    storeAgen(sBase, addrA, nextRand());      // oldest load named
    addrA = addrA ^ 32'h4;
    dispatchOp(1'b0);
    dispatchOp(1'b0);
    dispatchOp(1'b1);
    storeAgen(sBase + 2, addrA, nextRand());
    loadAgen(lBase + 2, addrA);               // forwards from the younger store
    storeAgen(sBase + 1, addrA, nextRand());  // no violation expected
    storeAgen(sBase + 2, addrA, stData[(sBase + 2) % D]);  // source store replays
    repeat (3) commitLoadOp();
    repeat (3) commitStoreOp();

    // committed store reaches memory
    addrA = pickAddr();
    sBase = stTail;
    dispatchOp(1'b0);
    storeAgen(sBase, addrA, nextRand());
    commitStoreOp();
    idleCycles(1);
    lBase = lqTail;
    dispatchOp(1'b1);
    loadAgen(lBase, addrA);
    commitLoadOp();

    // recovery with live entries
    dispatchOp(1'b1);
    dispatchOp(1'b0);
    recoverOp(lqTail - 1, pickAddr());
    dispatchOp(1'b0);
    commitLoadOp();
    commitStoreOp();
    idleCycles(2);
    checkVal("load credits held", ldCredits, D);
    checkVal("store credits held", stCredits, D);

    idleCycles(2);
    $display("checks: %0d, errors: %0d, stores to memory: %0d", checks, errors, storeCnt);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
